//--- tb/alu_cases.txt
# I <instruction word>, in program order from the reset pc
# E <pc> <wnum> <wdata>, expected register writes in order
I 142468a1
I 0399e021
I 02bffc02
I 037c3c43
I 00100c24
I 00110465
I 001210a6
I 001290a7
I 00148888
I 00150469
I 0015a12a
I 00100820
I 03400000
I 0015100b
I 03a0000c
I 02bff58d
I 0012b40e
E 1c000000 01 12345000
E 1c000004 01 12345678
E 1c000008 02 ffffffff
E 1c00000c 03 00000f0f
E 1c000010 04 12346587
E 1c000014 05 edcbb897
E 1c000018 06 00000001
E 1c00001c 07 00000000
E 1c000020 08 12346587
E 1c000024 09 12345f7f
E 1c000028 0a 00003af8
E 1c000034 0b 12346587
E 1c000038 0c 00000800
E 1c00003c 0d 000007fd
E 1c000040 0e 00000001

//--- vlog.f
+incdir+common
common/cpu_pkg.sv
src/pipe_stage.sv
fetch/inst_fetch.sv
src/decoder.sv
src/regfile.sv
src/alu_forward.sv
src/cpu_core.sv
tb/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_cpu_core -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb/tb_cpu_core.sv
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu_core;

    logic aclk;
    logic rst;
    logic req;
    logic wr;
    logic [1:0] size;
    logic [`CPU_XLEN-1:0] addr;
    logic [3:0] wstrb;
    logic addr_ok;
    logic data_ok;
    logic [`CPU_XLEN-1:0] rdata;
    cpu_pkg::wb_trace_t trace;

    logic [31:0] prog[$];
    logic [31:0] exp_pc[$];
    logic [4:0] exp_wnum[$];
    logic [31:0] exp_wdata[$];
    logic [31:0] next_fetch;
    int exp_idx;
    int passed;
    int failed;
    int errors;
    int cycles;
    int limit;
    int seed_ret;

    cpu_core i_dut (
        .aclk(aclk), .rst(rst), .req(req), .wr(wr), .size(size), .addr(addr),
        .wstrb(wstrb), .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .trace(trace)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    function automatic logic [31:0] fetch_word(input logic [31:0] a);
        logic [31:0] idx;
        idx = (a - `CPU_RESET_PC) >> 2;
        if (idx < prog.size()) begin
            return prog[idx];
        end
        return `CPU_NOP_INSTR;
    endfunction

    task automatic load_cases();
        int fd;
        int n;
        string line;
        string rest;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        fd = $fopen("tb/alu_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/alu_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 2 && (line[0] == "I" || line[0] == "E")) begin
                    rest = line.substr(1, line.len() - 1);
                    if (line[0] == "I") begin
                        n = $sscanf(rest, "%h", w0);
                        assert (n == 1) else begin
                            $display("malformed program line in case file: %s", line);
                            errors++;
                        end
                        prog.push_back(w0);
                    end else begin
                        n = $sscanf(rest, "%h %h %h", w0, w1, w2);
                        assert (n == 3) else begin
                            $display("malformed expect line in case file: %s", line);
                            errors++;
                        end
                        exp_pc.push_back(w0);
                        exp_wnum.push_back(w1[4:0]);
                        exp_wdata.push_back(w2);
                    end
                end
            end
            $fclose(fd);
            if (exp_pc.size() == 0) begin
                $display("case file holds no expected writes");
                errors++;
            end
        end
    endtask

    task automatic check_trace();
        logic ok;
        ok = 1'b1;
        if (exp_idx >= exp_pc.size()) begin
            $display("unexpected write to r%0d at pc %h after the last expected one",
                trace.wnum, trace.pc);
            errors++;
        end else begin
            assert (trace.pc == exp_pc[exp_idx]) else begin
                $display("FAIL trace.pc got %h expected %h", trace.pc, exp_pc[exp_idx]);
                ok = 1'b0;
            end
            assert (trace.wen == 4'hf) else begin
                $display("FAIL trace.wen got %h expected %h", trace.wen, 4'hf);
                ok = 1'b0;
            end
            assert (trace.wnum == exp_wnum[exp_idx]) else begin
                $display("FAIL trace.wnum got %h expected %h", trace.wnum, exp_wnum[exp_idx]);
                ok = 1'b0;
            end
            assert (trace.wdata == exp_wdata[exp_idx]) else begin
                $display("FAIL trace.wdata got %h expected %h",
                    trace.wdata, exp_wdata[exp_idx]);
                ok = 1'b0;
            end
            $display("test %0d: pc %h r%0d = %h %s", exp_idx, exp_pc[exp_idx],
                exp_wnum[exp_idx], exp_wdata[exp_idx], ok ? "ok" : "mismatch");
            if (ok) begin
                passed++;
            end else begin
                failed++;
            end
            exp_idx++;
        end
    endtask

    // trace and reset checks at mid cycle
    initial begin
        forever begin
            @(negedge aclk);
            cycles++;
            if (rst) begin
                assert (!req && trace.wen == 4'h0) else begin
                    $display("FAIL req/trace.wen got %h/%h expected 0/0", req, trace.wen);
                    errors++;
                end
            end
            if (trace.wen != 4'h0) begin
                check_trace();
            end
        end
    end

    // instruction memory with random addr_ok and data_ok delays
    initial begin
        logic rst_s;
        logic req_s;
        logic a_fire;
        logic d_fire;
        logic pend;
        logic [31:0] cur_addr;
        logic [31:0] pend_addr;
        int aok_wait;
        int dok_wait;
        seed_ret = $urandom(56806);
        pend = 1'b0;
        pend_addr = '0;
        aok_wait = 0;
        dok_wait = 0;
        forever begin
            @(negedge aclk);
            rst_s = rst;
            req_s = req;
            a_fire = req && addr_ok;
            d_fire = data_ok;
            cur_addr = addr;
            @(posedge aclk);
            #1;
            if (rst_s) begin
                addr_ok = 1'b0;
                data_ok = 1'b0;
                pend = 1'b0;
                aok_wait = $urandom_range(0, 3);
            end else begin
                if (d_fire) begin
                    data_ok = 1'b0;
                    pend = 1'b0;
                end
                if (a_fire) begin
                    assert (cur_addr == next_fetch) else begin
                        $display("FAIL addr got %h expected %h", cur_addr, next_fetch);
                        errors++;
                    end
                    assert (!wr && size == 2'd2 && wstrb == 4'h0) else begin
                        $display("FAIL wr/size/wstrb got %h/%h/%h expected 0/2/0",
                            wr, size, wstrb);
                        errors++;
                    end
                    next_fetch = cur_addr + 32'd4;
                    pend_addr = cur_addr;
                    pend = 1'b1;
                    dok_wait = $urandom_range(0, 3);
                    aok_wait = $urandom_range(0, 3);
                    addr_ok = (aok_wait == 0);
                end else if (req_s && !addr_ok) begin
                    if (aok_wait > 0) begin
                        aok_wait--;
                    end
                    if (aok_wait == 0) begin
                        addr_ok = 1'b1;
                    end
                end
                if (pend && !data_ok) begin
                    if (dok_wait == 0) begin
                        data_ok = 1'b1;
                        rdata = fetch_word(pend_addr);
                    end else begin
                        dok_wait--;
                    end
                end
            end
            // junk on rdata outside data_ok
            if (!data_ok) begin
                rdata = $urandom();
            end
        end
    end

    initial begin
        rst = 1'b1;
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata = '0;
        passed = 0;
        failed = 0;
        errors = 0;
        cycles = 0;
        exp_idx = 0;
        next_fetch = `CPU_RESET_PC;
        load_cases();
        limit = 10 * prog.size() + 100;
        repeat (8) @(posedge aclk);
        #1;
        rst = 1'b0;
        if (errors == 0) begin
            while (exp_idx < exp_pc.size() && cycles < limit) begin
                @(posedge aclk);
            end
            if (exp_idx < exp_pc.size()) begin
                $display("timeout after %0d cycles, trace stopped at %0d of %0d writes",
                    cycles, exp_idx, exp_pc.size());
                errors++;
            end else begin
                // nop tail must stay silent
                repeat (20) @(posedge aclk);
            end
        end
        $display("%0d tests: %0d passed, %0d failed, %0d other errors",
            exp_pc.size(), passed, failed, errors);
        if (failed == 0 && errors == 0 && passed == exp_pc.size()) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/cpu_core.sv
`default_nettype none

`include "cpu_defs.svh"

module cpu_core (
    input wire aclk,
    input wire rst,
    output logic req,
    output logic wr,
    output logic [1:0] size,
    output logic [`CPU_XLEN-1:0] addr,
    output logic [3:0] wstrb,
    input wire addr_ok,
    input wire data_ok,
    input wire [`CPU_XLEN-1:0] rdata,
    output cpu_pkg::wb_trace_t trace
);

    localparam cpu_pkg::if_id_t id_bubble = '{pc: '0, instr: `CPU_NOP_INSTR};
    localparam cpu_pkg::id_ex_t ex_bubble = '{
        pc: '0,
        alu_op: cpu_pkg::alu_add,
        src2_sel: cpu_pkg::src2_rk,
        reg_we: 1'b0,
        rd_num: '0,
        rj_val: '0,
        rk_val: '0,
        imm: '0
    };
    localparam cpu_pkg::ex_wb_t wb_bubble = '0;

    logic if_valid, id_valid, ex_valid, wb_valid;
    logic id_allow_in, ex_allow_in, wb_allow_in;
    cpu_pkg::if_id_t if_data, id_data;
    cpu_pkg::id_ex_t id_ex_in, ex_data;
    cpu_pkg::ex_wb_t ex_wb_in, wb_data, wb_fwd;
    cpu_pkg::alu_op_e alu_op;
    cpu_pkg::src2_sel_e src2_sel;
    logic reg_we, wb_we;
    logic [`CPU_REG_BITS-1:0] rd_num, rj_num, rk_num;
    logic [`CPU_XLEN-1:0] imm, rj_reg, rk_reg, rj_val, rk_val, ex_result;

    // read-only instruction port
    assign wr = 1'b0;
    assign size = 2'd2;
    assign wstrb = 4'b0;

    inst_fetch i_fetch (
        .aclk(aclk), .rst(rst), .req(req), .addr(addr), .addr_ok(addr_ok),
        .data_ok(data_ok), .rdata(rdata), .id_allow_in(id_allow_in),
        .if_valid(if_valid), .if_data(if_data)
    );

    pipe_stage #(.T(cpu_pkg::if_id_t), .bubble(id_bubble)) i_id_stage (
        .aclk(aclk), .rst(rst), .valid_in(if_valid), .data_in(if_data),
        .ready_go(1'b1), .allow_out(ex_allow_in), .allow_in(id_allow_in),
        .valid_out(id_valid), .data_out(id_data)
    );

    decoder i_decoder (
        .instr(id_data.instr), .alu_op(alu_op), .src2_sel(src2_sel), .reg_we(reg_we),
        .rd_num(rd_num), .rj_num(rj_num), .rk_num(rk_num), .imm(imm)
    );

    regfile i_regfile (
        .aclk(aclk), .rst(rst), .rj_num(rj_num), .rk_num(rk_num),
        .rj_val(rj_reg), .rk_val(rk_reg),
        .we(wb_we), .wnum(wb_data.rd_num), .wdata(wb_data.result)
    );

    alu_forward i_alu_forward (
        .rj_num(rj_num), .rk_num(rk_num), .rj_reg(rj_reg), .rk_reg(rk_reg),
        .ex_fwd(ex_wb_in), .wb_fwd(wb_fwd), .rj_val(rj_val), .rk_val(rk_val),
        .ex_in(ex_data), .result(ex_result)
    );

    assign id_ex_in = '{
        pc: id_data.pc, alu_op: alu_op, src2_sel: src2_sel, reg_we: reg_we,
        rd_num: rd_num, rj_val: rj_val, rk_val: rk_val, imm: imm
    };

    pipe_stage #(.T(cpu_pkg::id_ex_t), .bubble(ex_bubble)) i_ex_stage (
        .aclk(aclk), .rst(rst), .valid_in(id_valid), .data_in(id_ex_in),
        .ready_go(1'b1), .allow_out(wb_allow_in), .allow_in(ex_allow_in),
        .valid_out(ex_valid), .data_out(ex_data)
    );

    // doubles as the EX forwarding source
    assign ex_wb_in = '{
        pc: ex_data.pc, reg_we: ex_data.reg_we && ex_valid,
        rd_num: ex_data.rd_num, result: ex_result
    };

    pipe_stage #(.T(cpu_pkg::ex_wb_t), .bubble(wb_bubble)) i_wb_stage (
        .aclk(aclk), .rst(rst), .valid_in(ex_valid), .data_in(ex_wb_in),
        .ready_go(1'b1), .allow_out(1'b1), .allow_in(wb_allow_in),
        .valid_out(wb_valid), .data_out(wb_data)
    );

    assign wb_we = wb_valid && wb_data.reg_we;
    assign wb_fwd = '{
        pc: wb_data.pc, reg_we: wb_we, rd_num: wb_data.rd_num, result: wb_data.result
    };

    assign trace = '{
        pc: wb_data.pc,
        wen: (wb_we && wb_data.rd_num != '0) ? 4'hf : 4'h0,
        wnum: wb_data.rd_num,
        wdata: wb_data.result
    };

endmodule

`default_nettype wire

//--- src/alu_forward.sv
`default_nettype none

`include "cpu_defs.svh"

module alu_forward (
    input wire [`CPU_REG_BITS-1:0] rj_num,
    input wire [`CPU_REG_BITS-1:0] rk_num,
    input wire [`CPU_XLEN-1:0] rj_reg,
    input wire [`CPU_XLEN-1:0] rk_reg,
    input wire cpu_pkg::ex_wb_t ex_fwd,
    input wire cpu_pkg::ex_wb_t wb_fwd,
    output logic [`CPU_XLEN-1:0] rj_val,
    output logic [`CPU_XLEN-1:0] rk_val,
    input wire cpu_pkg::id_ex_t ex_in,
    output logic [`CPU_XLEN-1:0] result
);

    logic [`CPU_XLEN-1:0] src2;

    // youngest producer wins
    function automatic logic [`CPU_XLEN-1:0] pick_src(
        input logic [`CPU_REG_BITS-1:0] num,
        input logic [`CPU_XLEN-1:0] reg_val,
        input cpu_pkg::ex_wb_t ex,
        input cpu_pkg::ex_wb_t wb
    );
        logic [`CPU_XLEN-1:0] val;
        val = reg_val;
        if (num != '0) begin
            if (ex.reg_we && ex.rd_num == num) begin
                val = ex.result;
            end else if (wb.reg_we && wb.rd_num == num) begin
                val = wb.result;
            end
        end
        return val;
    endfunction

    assign rj_val = pick_src(rj_num, rj_reg, ex_fwd, wb_fwd);
    assign rk_val = pick_src(rk_num, rk_reg, ex_fwd, wb_fwd);

    assign src2 = (ex_in.src2_sel == cpu_pkg::src2_imm) ? ex_in.imm : ex_in.rk_val;

    always_comb begin
        case (ex_in.alu_op)
            cpu_pkg::alu_add: result = ex_in.rj_val + src2;
            cpu_pkg::alu_sub: result = ex_in.rj_val - src2;
            cpu_pkg::alu_and: result = ex_in.rj_val & src2;
            cpu_pkg::alu_or: result = ex_in.rj_val | src2;
            cpu_pkg::alu_xor: result = ex_in.rj_val ^ src2;
            cpu_pkg::alu_slt: begin
                result = {{(`CPU_XLEN-1){1'b0}}, $signed(ex_in.rj_val) < $signed(src2)};
            end
            cpu_pkg::alu_sltu: result = {{(`CPU_XLEN-1){1'b0}}, ex_in.rj_val < src2};
            // lu12i.w immediate already shifted
            cpu_pkg::alu_lui: result = src2;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/regfile.sv
`default_nettype none

`include "cpu_defs.svh"

module regfile (
    input wire aclk,
    input wire rst,
    input wire [`CPU_REG_BITS-1:0] rj_num,
    input wire [`CPU_REG_BITS-1:0] rk_num,
    output logic [`CPU_XLEN-1:0] rj_val,
    output logic [`CPU_XLEN-1:0] rk_val,
    input wire we,
    input wire [`CPU_REG_BITS-1:0] wnum,
    input wire [`CPU_XLEN-1:0] wdata
);

    logic [`CPU_XLEN-1:0] regs [1 << `CPU_REG_BITS];

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `CPU_REG_BITS); i++) begin
                regs[i] <= '0;
            end
        end else if (we && wnum != '0) begin
            regs[wnum] <= wdata;
        end
    end

    // r0 hardwired
    assign rj_val = (rj_num == '0) ? '0 : regs[rj_num];
    assign rk_val = (rk_num == '0) ? '0 : regs[rk_num];

endmodule

`default_nettype wire

//--- src/decoder.sv
`default_nettype none

`include "cpu_defs.svh"

module decoder (
    input wire [`CPU_XLEN-1:0] instr,
    output cpu_pkg::alu_op_e alu_op,
    output cpu_pkg::src2_sel_e src2_sel,
    output logic reg_we,
    output logic [`CPU_REG_BITS-1:0] rd_num,
    output logic [`CPU_REG_BITS-1:0] rj_num,
    output logic [`CPU_REG_BITS-1:0] rk_num,
    output logic [`CPU_XLEN-1:0] imm
);

    logic [16:0] op17;
    logic [9:0] op10;
    logic [6:0] op7;

    assign op17 = instr[31:15];
    assign op10 = instr[31:22];
    assign op7 = instr[31:25];

    assign rd_num = instr[4:0];
    assign rj_num = instr[9:5];
    assign rk_num = instr[14:10];

    always_comb begin
        // unknown words become a non-writing add
        alu_op = cpu_pkg::alu_add;
        src2_sel = cpu_pkg::src2_rk;
        reg_we = 1'b0;
        imm = '0;
        if (op7 == `CPU_OP_LU12I_W) begin
            alu_op = cpu_pkg::alu_lui;
            src2_sel = cpu_pkg::src2_imm;
            reg_we = 1'b1;
            imm = {instr[24:5], 12'b0};
        end else if (op10 == `CPU_OP_ADDI_W) begin
            src2_sel = cpu_pkg::src2_imm;
            reg_we = 1'b1;
            imm = {{20{instr[21]}}, instr[21:10]};
        end else if (op10 == `CPU_OP_ANDI || op10 == `CPU_OP_ORI) begin
            alu_op = (op10 == `CPU_OP_ANDI) ? cpu_pkg::alu_and : cpu_pkg::alu_or;
            src2_sel = cpu_pkg::src2_imm;
            reg_we = 1'b1;
            // logical immediates are zero extended
            imm = {20'b0, instr[21:10]};
        end else begin
            reg_we = 1'b1;
            case (op17)
                `CPU_OP_ADD_W: alu_op = cpu_pkg::alu_add;
                `CPU_OP_SUB_W: alu_op = cpu_pkg::alu_sub;
                `CPU_OP_SLT: alu_op = cpu_pkg::alu_slt;
                `CPU_OP_SLTU: alu_op = cpu_pkg::alu_sltu;
                `CPU_OP_AND: alu_op = cpu_pkg::alu_and;
                `CPU_OP_OR: alu_op = cpu_pkg::alu_or;
                `CPU_OP_XOR: alu_op = cpu_pkg::alu_xor;
                default: reg_we = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fetch/inst_fetch.sv
`default_nettype none

`include "cpu_defs.svh"

module inst_fetch (
    input wire aclk,
    input wire rst,
    output logic req,
    output logic [`CPU_XLEN-1:0] addr,
    input wire addr_ok,
    input wire data_ok,
    input wire [`CPU_XLEN-1:0] rdata,
    input wire id_allow_in,
    output logic if_valid,
    output cpu_pkg::if_id_t if_data
);

    logic [`CPU_XLEN-1:0] last_pc;
    logic [`CPU_XLEN-1:0] if_pc;
    logic if_busy;
    logic if_allow_in;
    logic addr_fire;

    // IF stage gates the request so at most one is in flight
    assign req = !rst && if_allow_in;
    assign addr = last_pc + `CPU_XLEN'd4;
    assign addr_fire = req && addr_ok;

    // next address is the last accepted one plus 4
    always_ff @(posedge aclk) begin
        if (rst) begin
            last_pc <= `CPU_RESET_PC - `CPU_XLEN'd4;
        end else if (addr_fire) begin
            last_pc <= addr;
        end
    end

    // IF stage holds the pc of the outstanding fetch
    pipe_stage #(
        .T(logic [`CPU_XLEN-1:0]),
        .bubble(`CPU_RESET_PC - `CPU_XLEN'd4)
    ) i_if_stage (
        .aclk(aclk),
        .rst(rst),
        .valid_in(addr_fire),
        .data_in(addr),
        .ready_go(data_ok),
        .allow_out(id_allow_in),
        .allow_in(if_allow_in),
        .valid_out(if_busy),
        .data_out(if_pc)
    );

    // rdata only lives in the data_ok cycle
    assign if_valid = if_busy && data_ok;
    assign if_data = '{pc: if_pc, instr: rdata};

    addr_hold_a: assert property (
        @(posedge aclk) disable iff (rst)
        req && !addr_ok |=> $stable(addr)
    );

    resp_matched_a: assert property (
        @(posedge aclk) disable iff (rst)
        data_ok |-> if_busy
    );

endmodule

`default_nettype wire

//--- src/pipe_stage.sv
`default_nettype none

module pipe_stage #(
    parameter type T = logic [31:0],
    parameter T bubble = '0
) (
    input wire aclk,
    input wire rst,
    input wire valid_in,
    input wire T data_in,
    input wire ready_go,
    input wire allow_out,
    output logic allow_in,
    output logic valid_out,
    output T data_out
);

    assign allow_in = !valid_out || (ready_go && allow_out);

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_out <= 1'b0;
            data_out <= bubble;
        end else if (allow_in) begin
            valid_out <= valid_in;
            // empty stage carries the bubble
            data_out <= valid_in ? data_in : bubble;
        end
    end

    hold_stable_a: assert property (
        @(posedge aclk) disable iff (rst)
        valid_out && !(ready_go && allow_out) |=> $stable(data_out)
    );

endmodule

`default_nettype wire

//--- common/cpu_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_lui
    } alu_op_e;

    typedef enum logic {
        src2_rk,
        src2_imm
    } src2_sel_e;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        alu_op_e alu_op;
        src2_sel_e src2_sel;
        logic reg_we;
        logic [`CPU_REG_BITS-1:0] rd_num;
        // operands already forwarded in decode
        logic [`CPU_XLEN-1:0] rj_val;
        logic [`CPU_XLEN-1:0] rk_val;
        logic [`CPU_XLEN-1:0] imm;
    } id_ex_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic reg_we;
        logic [`CPU_REG_BITS-1:0] rd_num;
        logic [`CPU_XLEN-1:0] result;
    } ex_wb_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [3:0] wen;
        logic [`CPU_REG_BITS-1:0] wnum;
        logic [`CPU_XLEN-1:0] wdata;
    } wb_trace_t;

endpackage

`default_nettype wire

//--- common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_XLEN 32
`define CPU_REG_BITS 5

`define CPU_RESET_PC 32'h1c000000
// andi r0, r0, 0
`define CPU_NOP_INSTR 32'h03400000

// 3R major opcodes in instr[31:15]
`define CPU_OP_ADD_W 17'h00020
`define CPU_OP_SUB_W 17'h00022
`define CPU_OP_SLT 17'h00024
`define CPU_OP_SLTU 17'h00025
`define CPU_OP_AND 17'h00029
`define CPU_OP_OR 17'h0002a
`define CPU_OP_XOR 17'h0002b

// 2RI12 major opcodes in instr[31:22]
`define CPU_OP_ADDI_W 10'h00a
`define CPU_OP_ANDI 10'h00d
`define CPU_OP_ORI 10'h00e

// 1RI20 major opcode in instr[31:25]
`define CPU_OP_LU12I_W 7'h0a

`endif
